/* ooo_patterns.txt */
# Columns: op rd rs1 rs2 imm expected_commit_value hold, all in hex
# Opcodes: 0 add, 1 sub, 2 and, 3 or, 4 xor, 5 slt, 6 addi, 7 sll
# test independent_ops
6 1 0 0 0005 00000005 0
6 2 0 0 fffd fffffffd 0
6 3 0 0 00ff 000000ff 0
6 4 0 0 0ff0 00000ff0 0
0 5 1 2 0000 00000002 0
1 6 1 2 0000 00000008 0
2 7 3 4 0000 000000f0 0
3 8 3 4 0000 00000fff 0
4 9 3 4 0000 00000f0f 0
5 a 2 1 0000 00000001 0
5 b 1 2 0000 00000000 0
7 c 1 0 0024 00000050 0
# test dependency_chain
0 1 1 1 0000 0000000a 0
0 1 1 1 0000 00000014 0
1 2 1 5 0000 00000012 0
4 3 2 1 0000 00000006 0
6 4 3 0 ffff 00000005 0
7 d 4 0 001f 80000000 0
5 e d 0 0000 00000001 0
3 f e c 0000 00000051 0
# test register_zero
6 0 1 0 0001 00000015 0
0 5 0 0 0000 00000000 0
3 6 0 1 0000 00000014 0
# test back_pressure
6 7 0 0 0011 00000011 1
6 8 7 0 0001 00000012 1
0 9 7 8 0000 00000023 1
1 a 9 7 0000 00000012 1
2 b 9 3 0000 00000002 1
4 c b a 0000 00000010 1
7 d c 0 0003 00000080 1
5 e b c 0000 00000001 1
0 f d e 0000 00000081 1
# test after_release
1 1 f 9 0000 0000005e 0
0 2 1 0 0000 0000005e 0
3 3 2 f 0000 000000df 0

/* tb.f */
+incdir+.
ooo_pkg.sv
rename_reg_file.sv
reorder_buffer.sv
reservation_station.sv
alu_unit.sv
ooo_core.sv
tb_ooo_core.sv

/* tb_ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

module tb_ooo_core import ooo_pkg::*; ();

    localparam int MAX_PAT        = 64;
    localparam int ACK_TIMEOUT    = 200;
    localparam int COMMIT_TIMEOUT = 2000;
    localparam int BLOCK_CYCLES   = 40;

    logic                       clk;
    logic                       rst;
    logic                       issue_req;
    alu_op_e                    issue_op;
    logic [`OOO_REG_W-1:0]      issue_rd;
    logic [`OOO_REG_W-1:0]      issue_rs1;
    logic [`OOO_REG_W-1:0]      issue_rs2;
    logic [15:0]                issue_imm;
    logic                       issue_ack;
    logic                       commit_req;
    logic [`OOO_REG_W-1:0]      commit_rd;
    logic [`OOO_DATA_W-1:0]     commit_data;
    logic                       commit_ack;

    // Pattern table, one row per instruction
    logic [2:0]                 pat_op [MAX_PAT];
    logic [`OOO_REG_W-1:0]      pat_rd [MAX_PAT];
    logic [`OOO_REG_W-1:0]      pat_rs1 [MAX_PAT];
    logic [`OOO_REG_W-1:0]      pat_rs2 [MAX_PAT];
    logic [15:0]                pat_imm [MAX_PAT];
    logic [`OOO_DATA_W-1:0]     pat_exp [MAX_PAT];
    logic                       pat_hold [MAX_PAT];
    string                      pat_name [MAX_PAT];
    int                         num_pat;

    // Shared between the issue and commit processes
    logic                       hold_active;
    int                         commits_done;
    int                         seed = 96785;

    ooo_core dut_i (.*);

    always #4 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic load_patterns();
        int    fd;
        int    n;
        string line;
        string word;
        string cur_name;
        fd = $fopen("ooo_patterns.txt", "r");
        assert (fd != 0) else abort_run("cannot open ooo_patterns.txt");
        cur_name = "unnamed";
        num_pat  = 0;
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2) continue;
            // Comment lines, "# test name" starts a new test
            if (line.getc(0) == "#") begin
                if ($sscanf(line, "# test %s", word) == 1) cur_name = word;
                continue;
            end
            assert (num_pat < MAX_PAT) else abort_run("too many lines in the pattern file");
            n = $sscanf(line, "%h %h %h %h %h %h %h", pat_op[num_pat], pat_rd[num_pat],
                        pat_rs1[num_pat], pat_rs2[num_pat], pat_imm[num_pat],
                        pat_exp[num_pat], pat_hold[num_pat]);
            assert (n == 7) else abort_run($sformatf("malformed pattern line: %s", line));
            pat_name[num_pat] = cur_name;
            num_pat++;
        end
        $fclose(fd);
    endtask

    task automatic wait_issue_ack(input logic level, input int idx);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            assert (cycles <= ACK_TIMEOUT) else abort_run($sformatf(
                "timeout waiting for issue_ack to become %0b on pattern %0d", level, idx));
        end while (issue_ack !== level);
    endtask

    task automatic drive_issue(input int idx);
        issue_op  <= alu_op_e'(pat_op[idx]);
        issue_rd  <= pat_rd[idx];
        issue_rs1 <= pat_rs1[idx];
        issue_rs2 <= pat_rs2[idx];
        issue_imm <= pat_imm[idx];
        issue_req <= 1'b1;
    endtask

    // Rest of the four-phase issue handshake
    task automatic complete_issue(input int idx);
        wait_issue_ack(1'b1, idx);
        issue_req <= 1'b0;
        wait_issue_ack(1'b0, idx);
    endtask

    task automatic run_issue();
        int   issued;
        int   held;
        int   cycles;
        logic in_hold;
        issued  = 0;
        held    = 0;
        in_hold = 1'b0;
        for (int i = 0; i < num_pat; i++) begin
            if (pat_hold[i] && !in_hold) begin
                // Hold group starts from an empty buffer
                cycles = 0;
                while (commits_done != issued) begin
                    @(posedge clk);
                    cycles++;
                    assert (cycles <= COMMIT_TIMEOUT)
                        else abort_run("timeout draining commits before a hold group");
                end
                hold_active <= 1'b1;
                held = 0;
            end
            if (!pat_hold[i] && in_hold) begin
                assert (!hold_active)
                    else abort_run("hold group ended before the reorder buffer filled");
            end
            in_hold = pat_hold[i];
            drive_issue(i);
            if (in_hold && held == `OOO_ROB_DEPTH) begin
                // Buffer is full, this request must wait
                repeat (BLOCK_CYCLES) begin
                    @(posedge clk);
                    assert (issue_ack === 1'b0)
                        else abort_run("issue_ack rose while the reorder buffer was full");
                end
                hold_active <= 1'b0;
            end
            complete_issue(i);
            if (in_hold) held++;
            issued++;
        end
    endtask

    task automatic run_commit();
        int cycles;
        int delay;
        for (int idx = 0; idx < num_pat; idx++) begin
            cycles = 0;
            do begin
                @(posedge clk);
                cycles++;
                assert (cycles <= COMMIT_TIMEOUT) else abort_run($sformatf(
                    "timeout waiting for commit_req of pattern %0d", idx));
            end while (commit_req !== 1'b1);
            assert (commit_rd === pat_rd[idx]) else abort_run($sformatf(
                "error %s pattern %0d commit_rd expected %0d actual %0d",
                pat_name[idx], idx, pat_rd[idx], commit_rd));
            assert (commit_data === pat_exp[idx]) else abort_run($sformatf(
                "error %s pattern %0d commit_data expected %h actual %h",
                pat_name[idx], idx, pat_exp[idx], commit_data));
            delay = $unsigned($random(seed)) % 4;
            repeat (delay) @(posedge clk);
            cycles = 0;
            while (hold_active) begin
                @(posedge clk);
                cycles++;
                assert (cycles <= COMMIT_TIMEOUT)
                    else abort_run("hold group was never released");
            end
            commit_ack <= 1'b1;
            cycles = 0;
            do begin
                @(posedge clk);
                cycles++;
                assert (cycles <= ACK_TIMEOUT) else abort_run($sformatf(
                    "commit_req stayed high after commit_ack on pattern %0d", idx));
            end while (commit_req !== 1'b0);
            commit_ack   <= 1'b0;
            commits_done <= idx + 1;
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        issue_req    = 1'b0;
        issue_op     = op_add;
        issue_rd     = '0;
        issue_rs1    = '0;
        issue_rs2    = '0;
        issue_imm    = '0;
        commit_ack   = 1'b0;
        hold_active  = 1'b0;
        commits_done = 0;
        load_patterns();
        repeat (16) begin
            @(posedge clk);
            assert (issue_ack === 1'b0 && commit_req === 1'b0)
                else abort_run("issue_ack or commit_req high during reset");
        end
        rst <= 1'b0;
        repeat (4) begin
            @(posedge clk);
            assert (issue_ack === 1'b0 && commit_req === 1'b0)
                else abort_run("issue_ack or commit_req high after reset with no request");
        end
        fork
            run_issue();
            run_commit();
        join
        // No stray commit once the stream is done
        repeat (10) begin
            @(posedge clk);
            assert (commit_req === 1'b0)
                else abort_run("commit_req rose with no instruction left");
        end
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* ooo_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

module ooo_core import ooo_pkg::*; (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     issue_req,
    input  wire alu_op_e            issue_op,
    input  wire [`OOO_REG_W-1:0]    issue_rd,
    input  wire [`OOO_REG_W-1:0]    issue_rs1,
    input  wire [`OOO_REG_W-1:0]    issue_rs2,
    input  wire [15:0]              issue_imm,
    output logic                    issue_ack,
    output logic                    commit_req,
    output logic [`OOO_REG_W-1:0]   commit_rd,
    output logic [`OOO_DATA_W-1:0]  commit_data,
    input  wire                     commit_ack
);

    logic                       issue_fire;
    logic [`OOO_TAG_W-1:0]      alloc_tag;
    logic                       rob_full;
    logic                       rs_full;
    logic [`OOO_DATA_W-1:0]     rs1_value;
    logic [`OOO_TAG_W-1:0]      rs1_tag;
    logic                       rs1_pending;
    logic [`OOO_DATA_W-1:0]     rs2_value;
    logic [`OOO_TAG_W-1:0]      rs2_tag;
    logic                       rs2_pending;
    logic                       lookup1_ready;
    logic [`OOO_DATA_W-1:0]     lookup1_value;
    logic                       lookup2_ready;
    logic [`OOO_DATA_W-1:0]     lookup2_value;
    logic                       disp_valid;
    alu_op_e                    disp_op;
    logic [`OOO_DATA_W-1:0]     disp_a;
    logic [`OOO_DATA_W-1:0]     disp_b;
    logic [15:0]                disp_imm;
    logic [`OOO_TAG_W-1:0]      disp_tag;
    logic                       cdb_valid;
    logic [`OOO_TAG_W-1:0]      cdb_tag;
    logic [`OOO_DATA_W-1:0]     cdb_data;
    logic                       commit_fire;
    logic [`OOO_TAG_W-1:0]      commit_tag;

    // Accept a new request only with room in both the buffer and the station
    assign issue_fire = issue_req && !issue_ack && !rob_full && !rs_full;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_ack <= 1'b0;
        end else if (issue_fire) begin
            issue_ack <= 1'b1;
        end else if (!issue_req) begin
            issue_ack <= 1'b0;
        end
    end

    rename_reg_file rename_reg_file_i (.*);

    reorder_buffer reorder_buffer_i (
        .lookup1_tag (rs1_tag),
        .lookup2_tag (rs2_tag),
        .*
    );

    reservation_station reservation_station_i (.*);

    alu_unit alu_unit_i (.*);

endmodule

`default_nettype wire

/* alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

module alu_unit import ooo_pkg::*; (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     disp_valid,
    input  wire alu_op_e            disp_op,
    input  wire [`OOO_DATA_W-1:0]   disp_a,
    input  wire [`OOO_DATA_W-1:0]   disp_b,
    input  wire [15:0]              disp_imm,
    input  wire [`OOO_TAG_W-1:0]    disp_tag,
    output logic                    cdb_valid,
    output logic [`OOO_TAG_W-1:0]   cdb_tag,
    output logic [`OOO_DATA_W-1:0]  cdb_data
);

    logic [`OOO_DATA_W-1:0] imm_ext;
    logic [`OOO_DATA_W-1:0] op_b;
    logic [`OOO_DATA_W-1:0] result;

    assign imm_ext = {{(`OOO_DATA_W - 16){disp_imm[15]}}, disp_imm};
    assign op_b    = (disp_op == op_addi) ? imm_ext : disp_b;

    always_comb begin
        case (disp_op)
            op_add, op_addi: result = disp_a + op_b;
            op_sub:          result = disp_a - op_b;
            op_and:          result = disp_a & op_b;
            op_or:           result = disp_a | op_b;
            op_xor:          result = disp_a ^ op_b;
            op_slt:          result = {{(`OOO_DATA_W - 1){1'b0}}, $signed(disp_a) < $signed(op_b)};
            // Shift amount comes from the immediate
            op_sll:          result = disp_a << disp_imm[4:0];
            default:         result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= disp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (disp_valid) begin
            cdb_tag  <= disp_tag;
            cdb_data <= result;
        end
    end

endmodule

`default_nettype wire

/* reservation_station.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

module reservation_station import ooo_pkg::*; (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     issue_fire,
    input  wire alu_op_e            issue_op,
    input  wire [15:0]              issue_imm,
    input  wire [`OOO_TAG_W-1:0]    alloc_tag,
    input  wire [`OOO_DATA_W-1:0]   rs1_value,
    input  wire [`OOO_TAG_W-1:0]    rs1_tag,
    input  wire                     rs1_pending,
    input  wire [`OOO_DATA_W-1:0]   rs2_value,
    input  wire [`OOO_TAG_W-1:0]    rs2_tag,
    input  wire                     rs2_pending,
    input  wire                     lookup1_ready,
    input  wire [`OOO_DATA_W-1:0]   lookup1_value,
    input  wire                     lookup2_ready,
    input  wire [`OOO_DATA_W-1:0]   lookup2_value,
    input  wire                     cdb_valid,
    input  wire [`OOO_TAG_W-1:0]    cdb_tag,
    input  wire [`OOO_DATA_W-1:0]   cdb_data,
    output logic                    rs_full,
    output logic                    disp_valid,
    output alu_op_e                 disp_op,
    output logic [`OOO_DATA_W-1:0]  disp_a,
    output logic [`OOO_DATA_W-1:0]  disp_b,
    output logic [15:0]             disp_imm,
    output logic [`OOO_TAG_W-1:0]   disp_tag
);

    localparam int IDX_W = $clog2(`OOO_RS_DEPTH);

    // Entry state with age 0 as the oldest live entry
    logic [`OOO_RS_DEPTH-1:0]   valid;
    logic [`OOO_RS_DEPTH-1:0]   ready1;
    logic [`OOO_RS_DEPTH-1:0]   ready2;
    logic [IDX_W-1:0]           age [`OOO_RS_DEPTH];
    alu_op_e                    e_op [`OOO_RS_DEPTH];
    logic [15:0]                e_imm [`OOO_RS_DEPTH];
    logic [`OOO_TAG_W-1:0]      e_tag [`OOO_RS_DEPTH];
    logic [`OOO_TAG_W-1:0]      q1 [`OOO_RS_DEPTH];
    logic [`OOO_TAG_W-1:0]      q2 [`OOO_RS_DEPTH];
    logic [`OOO_DATA_W-1:0]     val1 [`OOO_RS_DEPTH];
    logic [`OOO_DATA_W-1:0]     val2 [`OOO_RS_DEPTH];

    logic                       new_rdy1;
    logic                       new_rdy2;
    logic [`OOO_DATA_W-1:0]     new_val1;
    logic [`OOO_DATA_W-1:0]     new_val2;
    logic [IDX_W-1:0]           free_idx;
    logic [IDX_W-1:0]           new_age;
    logic [IDX_W:0]             live_cnt;
    logic [`OOO_RS_DEPTH-1:0]   wake1;
    logic [`OOO_RS_DEPTH-1:0]   wake2;
    logic                       sel_found;
    logic [IDX_W-1:0]           sel_idx;

    // Operand capture from the register file, else from the buffer lookup
    // The lookup already carries the bus result of this cycle
    always_comb begin
        new_rdy1 = 1'b1;
        new_val1 = rs1_value;
        if (rs1_pending) begin
            if (lookup1_ready) new_val1 = lookup1_value;
            else new_rdy1 = 1'b0;
        end
        new_rdy2 = 1'b1;
        new_val2 = rs2_value;
        // Immediate forms never wait on the second register
        if (rs2_pending && issue_op != op_addi && issue_op != op_sll) begin
            if (lookup2_ready) new_val2 = lookup2_value;
            else new_rdy2 = 1'b0;
        end
    end

    // Free slot, occupancy, wake-up and oldest-ready pick
    always_comb begin
        free_idx  = '0;
        live_cnt  = '0;
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = `OOO_RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid[i]) free_idx = IDX_W'(i);
        end
        for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
            live_cnt = live_cnt + {{IDX_W{1'b0}}, valid[i]};
            wake1[i] = valid[i] && !ready1[i] && cdb_valid && q1[i] == cdb_tag;
            wake2[i] = valid[i] && !ready2[i] && cdb_valid && q2[i] == cdb_tag;
            if (valid[i] && ready1[i] && ready2[i] &&
                (!sel_found || age[i] < age[sel_idx])) begin
                sel_found = 1'b1;
                sel_idx   = IDX_W'(i);
            end
        end
        new_age = IDX_W'(live_cnt - {{IDX_W{1'b0}}, sel_found});
    end

    assign rs_full = &valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid      <= '0;
            ready1     <= '0;
            ready2     <= '0;
            disp_valid <= 1'b0;
            for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
                age[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
                if (wake1[i]) ready1[i] <= 1'b1;
                if (wake2[i]) ready2[i] <= 1'b1;
                // Younger entries move up when one leaves
                if (sel_found && valid[i] && age[i] > age[sel_idx]) begin
                    age[i] <= age[i] - 1'b1;
                end
            end
            if (sel_found) valid[sel_idx] <= 1'b0;
            if (issue_fire) begin
                valid[free_idx]  <= 1'b1;
                ready1[free_idx] <= new_rdy1;
                ready2[free_idx] <= new_rdy2;
                age[free_idx]    <= new_age;
            end
            disp_valid <= sel_found;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
            if (wake1[i]) val1[i] <= cdb_data;
            if (wake2[i]) val2[i] <= cdb_data;
        end
        if (issue_fire) begin
            e_op[free_idx]  <= issue_op;
            e_imm[free_idx] <= issue_imm;
            e_tag[free_idx] <= alloc_tag;
            q1[free_idx]    <= rs1_tag;
            q2[free_idx]    <= rs2_tag;
            val1[free_idx]  <= new_val1;
            val2[free_idx]  <= new_val2;
        end
        if (sel_found) begin
            disp_op  <= e_op[sel_idx];
            disp_a   <= val1[sel_idx];
            disp_b   <= val2[sel_idx];
            disp_imm <= e_imm[sel_idx];
            disp_tag <= e_tag[sel_idx];
        end
    end

    // Operands sent to the ALU were really captured, never left unknown
    a_disp_ready: assert property (@(posedge clk) disable iff (rst)
        disp_valid |-> !$isunknown(disp_a) && !$isunknown(disp_b));

endmodule

`default_nettype wire

/* reorder_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

module reorder_buffer import ooo_pkg::*; (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     issue_fire,
    input  wire [`OOO_REG_W-1:0]    issue_rd,
    output logic [`OOO_TAG_W-1:0]   alloc_tag,
    output logic                    rob_full,
    input  wire [`OOO_TAG_W-1:0]    lookup1_tag,
    output logic                    lookup1_ready,
    output logic [`OOO_DATA_W-1:0]  lookup1_value,
    input  wire [`OOO_TAG_W-1:0]    lookup2_tag,
    output logic                    lookup2_ready,
    output logic [`OOO_DATA_W-1:0]  lookup2_value,
    input  wire                     cdb_valid,
    input  wire [`OOO_TAG_W-1:0]    cdb_tag,
    input  wire [`OOO_DATA_W-1:0]   cdb_data,
    output logic                    commit_req,
    input  wire                     commit_ack,
    output logic                    commit_fire,
    output logic [`OOO_TAG_W-1:0]   commit_tag,
    output logic [`OOO_REG_W-1:0]   commit_rd,
    output logic [`OOO_DATA_W-1:0]  commit_data
);

    logic [`OOO_TAG_W-1:0]      head;
    logic [`OOO_TAG_W-1:0]      tail;
    logic [`OOO_TAG_W:0]        count;
    logic [`OOO_ROB_DEPTH-1:0]  busy;
    logic [`OOO_ROB_DEPTH-1:0]  done;
    logic [`OOO_REG_W-1:0]      dest [`OOO_ROB_DEPTH];
    logic [`OOO_DATA_W-1:0]     value [`OOO_ROB_DEPTH];
    commit_state_e              state;

    assign alloc_tag = tail;
    assign rob_full  = (count == `OOO_ROB_DEPTH);

    // Operand lookups, bus result of this cycle wins
    always_comb begin
        lookup1_ready = done[lookup1_tag];
        lookup1_value = value[lookup1_tag];
        if (cdb_valid && cdb_tag == lookup1_tag) begin
            lookup1_ready = 1'b1;
            lookup1_value = cdb_data;
        end
        lookup2_ready = done[lookup2_tag];
        lookup2_value = value[lookup2_tag];
        if (cdb_valid && cdb_tag == lookup2_tag) begin
            lookup2_ready = 1'b1;
            lookup2_value = cdb_data;
        end
    end

    // Head entry is presented for the whole handshake
    assign commit_req  = (state == cs_req);
    assign commit_fire = commit_req && commit_ack;
    assign commit_tag  = head;
    assign commit_rd   = dest[head];
    assign commit_data = value[head];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            busy  <= '0;
            done  <= '0;
            state <= cs_idle;
        end else begin
            if (issue_fire) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (cdb_valid) begin
                done[cdb_tag] <= 1'b1;
            end
            if (commit_fire) begin
                busy[head] <= 1'b0;
                done[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            case ({issue_fire, commit_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case (state)
                cs_idle:     if (busy[head] && done[head]) state <= cs_req;
                cs_req:      if (commit_ack) state <= cs_wait_low;
                cs_wait_low: if (!commit_ack) state <= cs_idle;
                default:     state <= cs_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            dest[tail] <= issue_rd;
        end
        if (cdb_valid) begin
            value[cdb_tag] <= cdb_data;
        end
    end

    // Issue sequencer must respect back-pressure
    a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
        issue_fire |-> !rob_full);

    // Each ALU result belongs to a live entry and arrives once
    a_cdb_live: assert property (@(posedge clk) disable iff (rst)
        cdb_valid |-> busy[cdb_tag] && !done[cdb_tag]);

endmodule

`default_nettype wire

/* rename_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ooo_settings.svh"

module rename_reg_file (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     issue_fire,
    input  wire [`OOO_REG_W-1:0]    issue_rd,
    input  wire [`OOO_REG_W-1:0]    issue_rs1,
    input  wire [`OOO_REG_W-1:0]    issue_rs2,
    input  wire [`OOO_TAG_W-1:0]    alloc_tag,
    output logic [`OOO_DATA_W-1:0]  rs1_value,
    output logic [`OOO_TAG_W-1:0]   rs1_tag,
    output logic                    rs1_pending,
    output logic [`OOO_DATA_W-1:0]  rs2_value,
    output logic [`OOO_TAG_W-1:0]   rs2_tag,
    output logic                    rs2_pending,
    input  wire                     commit_fire,
    input  wire [`OOO_TAG_W-1:0]    commit_tag,
    input  wire [`OOO_REG_W-1:0]    commit_rd,
    input  wire [`OOO_DATA_W-1:0]   commit_data
);

    logic [`OOO_DATA_W-1:0]     reg_value [`OOO_NUM_REGS];
    logic [`OOO_TAG_W-1:0]      reg_tag [`OOO_NUM_REGS];
    logic [`OOO_NUM_REGS-1:0]   reg_pending;

    // Register 0 is never written or renamed, so plain reads give zero
    always_comb begin
        rs1_value   = reg_value[issue_rs1];
        rs1_tag     = reg_tag[issue_rs1];
        rs1_pending = reg_pending[issue_rs1];
        rs2_value   = reg_value[issue_rs2];
        rs2_tag     = reg_tag[issue_rs2];
        rs2_pending = reg_pending[issue_rs2];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reg_pending <= '0;
            for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                reg_value[i] <= '0;
                reg_tag[i]   <= '0;
            end
        end else begin
            if (commit_fire && commit_rd != '0) begin
                reg_value[commit_rd] <= commit_data;
                // Only the newest writer releases the rename
                if (reg_tag[commit_rd] == commit_tag) begin
                    reg_pending[commit_rd] <= 1'b0;
                end
            end
            // A new rename overrides a release in the same cycle
            if (issue_fire && issue_rd != '0) begin
                reg_pending[issue_rd] <= 1'b1;
                reg_tag[issue_rd]     <= alloc_tag;
            end
        end
    end

    // Every retiring destination was renamed at issue and not yet released
    a_commit_renamed: assert property (@(posedge clk) disable iff (rst)
        commit_fire && commit_rd != '0 |-> reg_pending[commit_rd]);

endmodule

`default_nettype wire

/* ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

    // ALU opcodes on the issue port
    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_and  = 3'd2,
        op_or   = 3'd3,
        op_xor  = 3'd4,
        op_slt  = 3'd5,
        op_addi = 3'd6,
        op_sll  = 3'd7
    } alu_op_e;

    // Commit handshake sequencer in the reorder buffer
    typedef enum logic [1:0] {
        cs_idle     = 2'd0,
        cs_req      = 2'd1,
        cs_wait_low = 2'd2
    } commit_state_e;

endpackage

`default_nettype wire

/* ooo_settings.svh */
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// Architectural registers, register 0 reads as zero
`define OOO_NUM_REGS 16
`define OOO_REG_W 4

// Reorder buffer, depth is 2**OOO_TAG_W so the pointers wrap on their own
`define OOO_ROB_DEPTH 8
`define OOO_TAG_W 3

// Reservation station entries
`define OOO_RS_DEPTH 4

// Data word
`define OOO_DATA_W 32

`endif
